/* logic/ctrl_pkg.sv */
/*
  core controller definitions
  shared encodings for the sequencer state, the fetch pc source,
  the control-transfer kind of a decoded instruction and the
  operand forwarding select
*/

`default_nettype none

package ctrl_pkg;

  // sequencer states, 4 bits leaves room for spare encodings
  typedef enum logic [3:0] {
    RESET       = 4'd0,
    BOOT_SET    = 4'd1,
    SLEEP       = 4'd2,
    FIRST_FETCH = 4'd3,
    DECODE      = 4'd4,
    FLUSH_EX    = 4'd5,
    FLUSH_WB    = 4'd6
  } ctrl_state_e;

  // fetch pc source, encodings follow the prefetcher mux
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100
  } pc_mux_e;

  // control transfer carried by an instruction
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_kind_e;

  // source of a register operand in ID
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

endpackage

`default_nettype wire

/* logic/ctrl_fsm.sv */
/*
  controller sequencer
  walks the core through boot, sleep, first fetch, decode and the
  wfi pipeline flush; issues fetch requests, pc redirects for jumps,
  taken branches and interrupts, stage halts and interrupt acknowledge
*/

`timescale 1ns/100ps
`default_nettype none

module ctrl_fsm import ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  // core and pipeline status
  input  logic       fetch_enable_i,
  input  logic       instr_valid_i,
  input  logic       id_ready_i,
  input  logic       ex_valid_i,
  input  logic       branch_taken_ex_i,
  input  jump_kind_e jump_in_dec_i,
  input  logic       pipe_flush_i,
  input  logic       ext_req_i,
  input  logic       jr_stall_i,

  output logic       ctrl_busy_o,
  output logic       is_decoding_o,
  output logic       instr_req_o,
  output logic       pc_set_o,
  output pc_mux_e    pc_mux_o,
  output logic       halt_if_o,
  output logic       halt_id_o,
  output logic       irq_ack_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // one-shot flag so a stalled jump redirects only once
  logic jump_done_q;
  logic jump_done_d;
  logic is_jump;

  assign is_jump = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);

  ////////////////////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // defaults for a running core
    state_d       = state_q;
    jump_done_d   = jump_done_q;
    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    is_decoding_o = 1'b0;
    pc_set_o      = 1'b0;
    pc_mux_o      = PC_BOOT;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    irq_ack_o     = 1'b0;

    case (state_q)
      // idle after reset until the core gets enabled
      RESET: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // load boot address into the fetch pc
      BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      // stopped, woken by enable or an interrupt
      SLEEP: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || ext_req_i) begin
          state_d = FIRST_FETCH;
        end
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH: begin
        if (id_ready_i) begin
          state_d = DECODE;
        end
        // interrupt before anything was decoded
        if (ext_req_i) begin
          pc_set_o  = 1'b1;
          pc_mux_o  = PC_EXCEPTION;
          irq_ack_o = 1'b1;
        end
      end

      DECODE: begin
        if (branch_taken_ex_i) begin
          // branch in EX wins, the ID instruction is on the wrong path
          pc_set_o = 1'b1;
          pc_mux_o = PC_BRANCH;
          if (ext_req_i) begin
            pc_mux_o  = PC_EXCEPTION;
            irq_ack_o = 1'b1;
            halt_id_o = 1'b1;
          end
        end else if (instr_valid_i) begin
          is_decoding_o = 1'b1;

          if (is_jump) begin
            // target known in ID, redirect once the jr hazard clears
            pc_mux_o = PC_JUMP;
            if (!jr_stall_i && !jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end else if (ext_req_i) begin
            // keep the ID instruction out of EX
            pc_set_o  = 1'b1;
            pc_mux_o  = PC_EXCEPTION;
            irq_ack_o = 1'b1;
            halt_id_o = 1'b1;
          end

          // wfi, drain EX and WB before sleeping
          if (pipe_flush_i) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end else if (ext_req_i) begin
          // empty ID slot, take the interrupt right away
          pc_set_o  = 1'b1;
          pc_mux_o  = PC_EXCEPTION;
          irq_ack_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end

      // wait for the EX stage to finish
      FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = FLUSH_WB;
        end
      end

      // WB done after one cycle
      FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          halt_if_o = 1'b0;
          state_d   = DECODE;
        end else begin
          state_d = SLEEP;
        end
      end

      // spare encodings fall back to reset
      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // released once ID accepts the next instruction
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

`default_nettype wire

/* logic/hazard_unit.sv */
/*
  hazard detection
  raises load-use, jump-register and csr-use stalls for the ID
  stage and decides when the ID write enable must be dropped
*/

`timescale 1ns/100ps
`default_nettype none

module hazard_unit import ctrl_pkg::*; #(
  parameter int unsigned N_OPERANDS = 3
) (
  input  logic                  is_decoding_i,
  input  logic                  illegal_insn_i,
  input  logic                  data_req_ex_i,

  // pending register writes
  input  logic                  regfile_we_ex_i,
  input  logic                  regfile_we_wb_i,
  input  logic                  regfile_alu_we_fw_i,

  // destination matches, one bit per source operand
  input  logic [N_OPERANDS-1:0] reg_d_ex_match_i,
  input  logic [N_OPERANDS-1:0] reg_d_wb_match_i,
  input  logic [N_OPERANDS-1:0] reg_d_alu_match_i,

  input  logic                  csr_busy_i,
  input  logic                  csr_access_id_i,
  input  jump_kind_e            jump_in_dec_i,

  output logic                  load_stall_o,
  output logic                  jr_stall_o,
  output logic                  csr_stall_o,
  output logic                  deassert_we_o
);

  logic jr_dep;

  // load in EX writing any register that ID reads
  assign load_stall_o = data_req_ex_i & regfile_we_ex_i & (|reg_d_ex_match_i);

  // csr write in flight while ID reads a csr
  assign csr_stall_o = csr_busy_i & csr_access_id_i;

  // operand 0 carries the jalr base, any pending write to it blocks the target
  assign jr_dep = (regfile_we_wb_i     & reg_d_wb_match_i[0])  |
                  (regfile_we_ex_i     & reg_d_ex_match_i[0])  |
                  (regfile_alu_we_fw_i & reg_d_alu_match_i[0]);

  // independent of is_decoding so the sequencer loop stays open
  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) & jr_dep;

  // no write for a stalled, illegal or non-decoded instruction
  assign deassert_we_o = load_stall_o   |
                         csr_stall_o    |
                         jr_stall_o     |
                         illegal_insn_i |
                         ~is_decoding_i;

endmodule

`default_nettype wire

/* logic/operand_fwd_unit.sv */
/*
  operand forwarding select
  picks, for each ID source operand, the register file value or
  the result pending in EX or WB; the younger EX result wins
*/

`timescale 1ns/100ps
`default_nettype none

module operand_fwd_unit import ctrl_pkg::*; #(
  parameter int unsigned N_OPERANDS = 3
) (
  input  logic                       regfile_we_wb_i,
  input  logic                       regfile_alu_we_fw_i,
  input  logic [N_OPERANDS-1:0]      reg_d_wb_match_i,
  input  logic [N_OPERANDS-1:0]      reg_d_alu_match_i,

  // one select per operand
  output fw_sel_e [N_OPERANDS-1:0]   operand_fw_sel_o
);

  always_comb begin
    for (int unsigned i = 0; i < N_OPERANDS; i++) begin
      // default read from the register file
      operand_fw_sel_o[i] = SEL_REGFILE;

      // older result still in WB
      if (regfile_we_wb_i && reg_d_wb_match_i[i]) begin
        operand_fw_sel_o[i] = SEL_FW_WB;
      end

      // EX result is newer, overrides WB
      if (regfile_alu_we_fw_i && reg_d_alu_match_i[i]) begin
        operand_fw_sel_o[i] = SEL_FW_EX;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/core_controller.sv */
/*
  core controller top
  ties the sequencer, hazard detection and operand forwarding
  to the pipeline; all outputs are combinational in the state
  and the current inputs
*/

`timescale 1ns/100ps
`default_nettype none

module core_controller import ctrl_pkg::*; #(
  parameter int unsigned N_OPERANDS = 3
) (
  input  logic                     clk,
  input  logic                     rst_n,

  // pipeline status
  input  logic                     fetch_enable_i,
  input  logic                     instr_valid_i,
  input  logic                     id_ready_i,
  input  logic                     ex_valid_i,
  input  logic                     branch_taken_ex_i,
  // kind of the instruction handed to EX
  input  jump_kind_e               jump_in_id_i,
  // kind of the instruction being decoded
  input  jump_kind_e               jump_in_dec_i,
  input  logic                     pipe_flush_i,
  input  logic                     illegal_insn_i,
  input  logic                     ext_req_i,
  input  logic                     data_req_ex_i,
  input  logic                     csr_busy_i,
  input  logic                     csr_access_id_i,

  // register write enables in flight
  input  logic                     regfile_we_ex_i,
  input  logic                     regfile_we_wb_i,
  input  logic                     regfile_alu_we_fw_i,

  // destination matches per source operand
  input  logic [N_OPERANDS-1:0]    reg_d_ex_match_i,
  input  logic [N_OPERANDS-1:0]    reg_d_wb_match_i,
  input  logic [N_OPERANDS-1:0]    reg_d_alu_match_i,

  output logic                     ctrl_busy_o,
  output logic                     is_decoding_o,
  output logic                     instr_req_o,
  output logic                     pc_set_o,
  output pc_mux_e                  pc_mux_o,
  output logic                     halt_if_o,
  output logic                     halt_id_o,
  output logic                     irq_ack_o,
  output logic                     deassert_we_o,
  output logic                     load_stall_o,
  output logic                     jr_stall_o,
  output logic                     csr_stall_o,
  output fw_sel_e [N_OPERANDS-1:0] operand_fw_sel_o
);

  ////////////////////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////////////////////

  ctrl_fsm u_ctrl_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .pipe_flush_i      (pipe_flush_i),
    .ext_req_i         (ext_req_i),
    // jr stall feeds back from the hazard check
    .jr_stall_i        (jr_stall_o),
    .ctrl_busy_o       (ctrl_busy_o),
    .is_decoding_o     (is_decoding_o),
    .instr_req_o       (instr_req_o),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o),
    .irq_ack_o         (irq_ack_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // combinational checkers
  ////////////////////////////////////////////////////////////////////////////

  hazard_unit #(
    .N_OPERANDS (N_OPERANDS)
  ) u_hazard_unit (
    .is_decoding_i       (is_decoding_o),
    .illegal_insn_i      (illegal_insn_i),
    .data_req_ex_i       (data_req_ex_i),
    .regfile_we_ex_i     (regfile_we_ex_i),
    .regfile_we_wb_i     (regfile_we_wb_i),
    .regfile_alu_we_fw_i (regfile_alu_we_fw_i),
    .reg_d_ex_match_i    (reg_d_ex_match_i),
    .reg_d_wb_match_i    (reg_d_wb_match_i),
    .reg_d_alu_match_i   (reg_d_alu_match_i),
    .csr_busy_i          (csr_busy_i),
    .csr_access_id_i     (csr_access_id_i),
    .jump_in_dec_i       (jump_in_dec_i),
    .load_stall_o        (load_stall_o),
    .jr_stall_o          (jr_stall_o),
    .csr_stall_o         (csr_stall_o),
    .deassert_we_o       (deassert_we_o)
  );

  // forwarding needs no state, only the pending writes
  operand_fwd_unit #(
    .N_OPERANDS (N_OPERANDS)
  ) u_operand_fwd_unit (
    .regfile_we_wb_i     (regfile_we_wb_i),
    .regfile_alu_we_fw_i (regfile_alu_we_fw_i),
    .reg_d_wb_match_i    (reg_d_wb_match_i),
    .reg_d_alu_match_i   (reg_d_alu_match_i),
    .operand_fw_sel_o    (operand_fw_sel_o)
  );

endmodule

`default_nettype wire

/* verif/tb_vectors.svh */
/*
  core controller test vectors
  one row per clock cycle, applied on the falling edge after reset,
  grouped by the behavior under test
*/

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int N_ROWS  = 33;

// test groups, one summary line each
localparam int T_BOOT  = 0;
localparam int T_JUMP  = 1;
localparam int T_IRQ   = 2;
localparam int T_FLUSH = 3;
localparam int T_STALL = 4;
localparam int T_FWD   = 5;

// columns: test, ctrl, jump_in_dec, hazard, match, exp ctrl, exp pc_mux, exp stall, exp fw
//   ctrl      {fetch_en, instr_valid, id_ready, ex_valid, br_taken, pipe_flush, ext_req, illegal}
//   hazard    {data_req_ex, csr_busy, csr_access_id, we_ex, we_wb, alu_we_fw}
//   match     octal digits {ex, wb, alu}, bit i is operand i
//   exp ctrl  {busy, is_decoding, instr_req, pc_set, halt_if, halt_id, irq_ack}
//   exp mux   compared only where pc_set is expected high
//   exp stall {load_stall, jr_stall, csr_stall, deassert_we}
//   exp fw    {op2, op1, op0}, 00 regfile, 01 EX, 10 WB
task automatic fill_vectors();
  begin
    // idle in reset, then boot pc for one cycle, first fetch holds until ID ready
    add_row(T_BOOT, 8'h00, BRANCH_NONE, 6'h00, 9'o000, 7'h00, PC_BOOT, 4'h1, 6'b00_00_00);
    add_row(T_BOOT, 8'h80, BRANCH_NONE, 6'h00, 9'o000, 7'h00, PC_BOOT, 4'h1, 6'b00_00_00);
    add_row(T_BOOT, 8'h80, BRANCH_NONE, 6'h00, 9'o000, 7'h58, PC_BOOT, 4'h1, 6'b00_00_00);
    add_row(T_BOOT, 8'h80, BRANCH_NONE, 6'h00, 9'o000, 7'h50, PC_BOOT, 4'h1, 6'b00_00_00);
    add_row(T_BOOT, 8'h80, BRANCH_NONE, 6'h00, 9'o000, 7'h50, PC_BOOT, 4'h1, 6'b00_00_00);
    add_row(T_BOOT, 8'ha0, BRANCH_NONE, 6'h00, 9'o000, 7'h50, PC_BOOT, 4'h1, 6'b00_00_00);
    // jal with ID stalled, one redirect only
    add_row(T_JUMP, 8'hc0, BRANCH_JAL, 6'h00, 9'o000, 7'h78, PC_JUMP, 4'h0, 6'b00_00_00);
    add_row(T_JUMP, 8'hc0, BRANCH_JAL, 6'h00, 9'o000, 7'h70, PC_JUMP, 4'h0, 6'b00_00_00);
    add_row(T_JUMP, 8'hc0, BRANCH_JAL, 6'h00, 9'o000, 7'h70, PC_JUMP, 4'h0, 6'b00_00_00);
    add_row(T_JUMP, 8'he0, BRANCH_JAL, 6'h00, 9'o000, 7'h70, PC_JUMP, 4'h0, 6'b00_00_00);
    // taken branch, ID not decoding
    add_row(T_JUMP, 8'he8, BRANCH_NONE, 6'h00, 9'o000, 7'h58, PC_BRANCH, 4'h1, 6'b00_00_00);
    // interrupt in decode, then together with a taken branch
    add_row(T_IRQ, 8'he2, BRANCH_NONE, 6'h00, 9'o000, 7'h7b, PC_EXCEPTION, 4'h0, 6'b00_00_00);
    add_row(T_IRQ, 8'hea, BRANCH_NONE, 6'h00, 9'o000, 7'h5b, PC_EXCEPTION, 4'h1, 6'b00_00_00);
    // wfi flush, EX wait, WB, sleep, wake on interrupt
    add_row(T_FLUSH, 8'he4, BRANCH_NONE, 6'h00, 9'o000, 7'h76, PC_BOOT, 4'h0, 6'b00_00_00);
    add_row(T_FLUSH, 8'h00, BRANCH_NONE, 6'h00, 9'o000, 7'h56, PC_BOOT, 4'h1, 6'b00_00_00);
    add_row(T_FLUSH, 8'h10, BRANCH_NONE, 6'h00, 9'o000, 7'h56, PC_BOOT, 4'h1, 6'b00_00_00);
    add_row(T_FLUSH, 8'h00, BRANCH_NONE, 6'h00, 9'o000, 7'h56, PC_BOOT, 4'h1, 6'b00_00_00);
    add_row(T_FLUSH, 8'h00, BRANCH_NONE, 6'h00, 9'o000, 7'h06, PC_BOOT, 4'h1, 6'b00_00_00);
    add_row(T_FLUSH, 8'h02, BRANCH_NONE, 6'h00, 9'o000, 7'h06, PC_BOOT, 4'h1, 6'b00_00_00);
    add_row(T_FLUSH, 8'h82, BRANCH_NONE, 6'h00, 9'o000, 7'h59, PC_EXCEPTION, 4'h1, 6'b00_00_00);
    add_row(T_FLUSH, 8'ha0, BRANCH_NONE, 6'h00, 9'o000, 7'h50, PC_BOOT, 4'h1, 6'b00_00_00);
    // load-use, csr, jalr on operand 0, jalr released, matched jal, illegal
    add_row(T_STALL, 8'he0, BRANCH_NONE, 6'h24, 9'o200, 7'h70, PC_BOOT, 4'h9, 6'b00_00_00);
    add_row(T_STALL, 8'he0, BRANCH_NONE, 6'h18, 9'o000, 7'h70, PC_BOOT, 4'h3, 6'b00_00_00);
    add_row(T_STALL, 8'he0, BRANCH_JALR, 6'h02, 9'o010, 7'h70, PC_JUMP, 4'h5, 6'b00_00_10);
    add_row(T_STALL, 8'he0, BRANCH_JALR, 6'h00, 9'o000, 7'h78, PC_JUMP, 4'h0, 6'b00_00_00);
    add_row(T_STALL, 8'he0, BRANCH_JAL, 6'h04, 9'o100, 7'h78, PC_JUMP, 4'h0, 6'b00_00_00);
    add_row(T_STALL, 8'he1, BRANCH_NONE, 6'h00, 9'o000, 7'h70, PC_BOOT, 4'h1, 6'b00_00_00);
    // jalr with only operand 1 pending
    add_row(T_STALL, 8'he0, BRANCH_JALR, 6'h01, 9'o002, 7'h78, PC_JUMP, 4'h0, 6'b00_01_00);
    // forwarding priority, EX over WB, no select without write enable
    add_row(T_FWD, 8'he0, BRANCH_NONE, 6'h02, 9'o070, 7'h70, PC_BOOT, 4'h0, 6'b10_10_10);
    add_row(T_FWD, 8'he0, BRANCH_NONE, 6'h01, 9'o004, 7'h70, PC_BOOT, 4'h0, 6'b01_00_00);
    add_row(T_FWD, 8'he0, BRANCH_NONE, 6'h03, 9'o036, 7'h70, PC_BOOT, 4'h0, 6'b01_01_10);
    add_row(T_FWD, 8'he0, BRANCH_NONE, 6'h00, 9'o077, 7'h70, PC_BOOT, 4'h0, 6'b00_00_00);
    add_row(T_FWD, 8'he0, BRANCH_NONE, 6'h02, 9'o077, 7'h70, PC_BOOT, 4'h0, 6'b10_10_10);
  end
endtask

`endif

/* verif/tb_core_controller.sv */
/*
  core controller testbench
  drives the controller through boot, jumps, interrupts, the wfi
  flush, stalls and forwarding from a per-cycle vector table and
  checks every output a little after each falling edge
*/

`timescale 1ns/100ps
`default_nettype none

module tb_core_controller import ctrl_pkg::*; ();

  localparam int N_OPERANDS = 3;
  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 8;

  logic clk;
  logic rst_n;

  // DUT inputs
  logic fetch_enable, instr_valid, id_ready, ex_valid, branch_taken_ex;
  logic pipe_flush, illegal_insn, ext_req, data_req_ex, csr_busy, csr_access_id;
  logic regfile_we_ex, regfile_we_wb, regfile_alu_we_fw;
  jump_kind_e jump_in_id;
  jump_kind_e jump_in_dec;
  logic [N_OPERANDS-1:0] reg_d_ex_match, reg_d_wb_match, reg_d_alu_match;

  // DUT outputs
  logic ctrl_busy, is_decoding, instr_req, pc_set, halt_if, halt_id, irq_ack;
  logic deassert_we, load_stall, jr_stall, csr_stall;
  pc_mux_e pc_mux;
  fw_sel_e [N_OPERANDS-1:0] operand_fw_sel;

  `include "tb_vectors.svh"

  // packed rows in the order of the table columns
  int          row_test [N_ROWS];
  logic [24:0] row_in   [N_ROWS];
  logic [19:0] row_exp  [N_ROWS];
  int          row_count;
  int          check_count;
  int          fail_count;

  core_controller #(
    .N_OPERANDS (N_OPERANDS)
  ) u_core_controller (
    .clk (clk), .rst_n (rst_n),
    .fetch_enable_i (fetch_enable), .instr_valid_i (instr_valid), .id_ready_i (id_ready),
    .ex_valid_i (ex_valid), .branch_taken_ex_i (branch_taken_ex),
    .jump_in_id_i (jump_in_id), .jump_in_dec_i (jump_in_dec), .pipe_flush_i (pipe_flush),
    .illegal_insn_i (illegal_insn), .ext_req_i (ext_req), .data_req_ex_i (data_req_ex),
    .csr_busy_i (csr_busy), .csr_access_id_i (csr_access_id),
    .regfile_we_ex_i (regfile_we_ex), .regfile_we_wb_i (regfile_we_wb),
    .regfile_alu_we_fw_i (regfile_alu_we_fw), .reg_d_ex_match_i (reg_d_ex_match),
    .reg_d_wb_match_i (reg_d_wb_match), .reg_d_alu_match_i (reg_d_alu_match),
    .ctrl_busy_o (ctrl_busy), .is_decoding_o (is_decoding), .instr_req_o (instr_req),
    .pc_set_o (pc_set), .pc_mux_o (pc_mux), .halt_if_o (halt_if), .halt_id_o (halt_id),
    .irq_ack_o (irq_ack), .deassert_we_o (deassert_we), .load_stall_o (load_stall),
    .jr_stall_o (jr_stall), .csr_stall_o (csr_stall), .operand_fw_sel_o (operand_fw_sel)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // table handling
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_row(input int test, input logic [7:0] ctrl, input jump_kind_e jump,
                         input logic [5:0] hz, input logic [8:0] match,
                         input logic [6:0] exp_ctrl, input pc_mux_e exp_mux,
                         input logic [3:0] exp_stall, input logic [5:0] exp_fw);
    if (row_count < N_ROWS) begin
      row_test[row_count] = test;
      row_in[row_count]   = {ctrl, jump, hz, match};
      row_exp[row_count]  = {exp_ctrl, exp_mux, exp_stall, exp_fw};
    end
    row_count++;
  endtask

  task automatic apply_row(input int r);
    logic [24:0] v;
    v = row_in[r];
    {fetch_enable, instr_valid, id_ready, ex_valid} = v[24:21];
    {branch_taken_ex, pipe_flush, ext_req, illegal_insn} = v[20:17];
    jump_in_dec = jump_kind_e'(v[16:15]);
    // a taken branch means a conditional branch sits in EX
    jump_in_id  = v[20] ? BRANCH_COND : BRANCH_NONE;
    {data_req_ex, csr_busy, csr_access_id} = v[14:12];
    {regfile_we_ex, regfile_we_wb, regfile_alu_we_fw} = v[11:9];
    {reg_d_ex_match, reg_d_wb_match, reg_d_alu_match} = v[8:0];
  endtask

  task automatic check_value(input string name, input int r, input logic [7:0] got,
                             input logic [7:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("[ERROR] row %0d %s expected %h got %h", r, name, exp, got);
      fail_count++;
    end
  endtask

  task automatic check_row(input int r);
    logic [19:0] e;
    e = row_exp[r];
    check_value("ctrl_busy_o", r, ctrl_busy, e[19]);
    check_value("is_decoding_o", r, is_decoding, e[18]);
    check_value("instr_req_o", r, instr_req, e[17]);
    check_value("pc_set_o", r, pc_set, e[16]);
    check_value("halt_if_o", r, halt_if, e[15]);
    check_value("halt_id_o", r, halt_id, e[14]);
    check_value("irq_ack_o", r, irq_ack, e[13]);
    // pc source only matters with a redirect
    if (e[16]) begin
      check_value("pc_mux_o", r, pc_mux, e[12:10]);
    end
    check_value("load_stall_o", r, load_stall, e[9]);
    check_value("jr_stall_o", r, jr_stall, e[8]);
    check_value("csr_stall_o", r, csr_stall, e[7]);
    check_value("deassert_we_o", r, deassert_we, e[6]);
    for (int i = 0; i < N_OPERANDS; i++) begin
      check_value($sformatf("operand_fw_sel_o[%0d]", i), r, operand_fw_sel[i], e[2*i +: 2]);
    end
  endtask

  function automatic string test_name(input int id);
    case (id)
      T_BOOT:  return "reset_boot";
      T_JUMP:  return "jump_branch";
      T_IRQ:   return "interrupt";
      T_FLUSH: return "flush_sleep";
      T_STALL: return "stalls";
      default: return "forwarding";
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and summary
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int fails_before;
    int test_fails;
    rst_n = 1'b0;
    {fetch_enable, instr_valid, id_ready, ex_valid, branch_taken_ex} = '0;
    {pipe_flush, illegal_insn, ext_req, data_req_ex, csr_busy, csr_access_id} = '0;
    {regfile_we_ex, regfile_we_wb, regfile_alu_we_fw} = '0;
    jump_in_id = BRANCH_NONE;
    jump_in_dec = BRANCH_NONE;
    {reg_d_ex_match, reg_d_wb_match, reg_d_alu_match} = '0;
    row_count = 0;
    check_count = 0;
    fail_count = 0;
    test_fails = 0;
    fill_vectors();
    if (row_count != N_ROWS) begin
      $display("vector table holds %0d rows but %0d were expected", row_count, N_ROWS);
      fail_count++;
    end

    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    for (int r = 0; r < N_ROWS; r++) begin
      @(negedge clk);
      apply_row(r);
      // let the combinational outputs settle before the rising edge
      #2;
      fails_before = fail_count;
      check_row(r);
      test_fails += fail_count - fails_before;
      if (r == N_ROWS - 1 || row_test[r + 1] != row_test[r]) begin
        $display("test %-12s %s, %0d errors", test_name(row_test[r]),
                 (test_fails == 0) ? "ok" : "failed", test_fails);
        test_fails = 0;
      end
    end

    $display("checks passed %0d, failed %0d", check_count - fail_count, fail_count);
    if (fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // covers reset and every row with some slack
  initial begin : watchdog
    #((RST_CYCLES + N_ROWS + 20) * CLK_PERIOD);
    $display("timeout, the vector loop did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+verif
logic/ctrl_pkg.sv
logic/ctrl_fsm.sv
logic/hazard_unit.sv
logic/operand_fwd_unit.sv
logic/core_controller.sv
verif/tb_core_controller.sv
